// File: cpu_commit.sv
`timescale 1ns/100ps
// Commit stage: holds the last record, writes back and drives the commit channel
module cpu_commit (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   exe_valid,
  output logic                   exe_ready,
  input  cpu_pipe_pkg::cmt_rec_t exe_rec,
  output logic                   cmt_valid,
  input  logic                   cmt_ready,
  output cpu_pipe_pkg::cmt_rec_t cmt_rec,
  output logic                   wb_en,
  output cpu_isa_pkg::reg_idx_t  wb_idx,
  output cpu_isa_pkg::word_t     wb_data,
  output cpu_isa_pkg::reg_idx_t  busy_rd,
  output logic                   busy_en
);

  logic exe_xfer;
  logic cmt_xfer;

  assign exe_ready = !cmt_valid || cmt_ready;
  assign exe_xfer  = exe_valid && exe_ready;
  assign cmt_xfer  = cmt_valid && cmt_ready;

  ////////////////////
  // Commit register
  always_ff @(posedge clk) begin
    if (reset) begin
      cmt_valid <= 1'b0;
    end else if (exe_xfer) begin
      cmt_valid <= 1'b1;
    end else if (cmt_ready) begin
      cmt_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (exe_xfer) begin
      cmt_rec <= exe_rec;
    end
  end

  ////////////////////
  // Writeback lands with the commit transfer
  assign wb_en   = cmt_xfer && cmt_rec.wr_en;
  assign wb_idx  = cmt_rec.rd;
  assign wb_data = cmt_rec.result;

  // Still in flight until it leaves
  assign busy_rd = cmt_rec.rd;
  assign busy_en = cmt_valid && cmt_rec.wr_en;

  // Held record stays put under back-pressure
  a_cmt_hold: assert property (
    @(posedge clk) disable iff (reset)
    cmt_valid && !cmt_ready |=> cmt_valid && $stable(cmt_rec)
  );

endmodule

// File: cpu_core.f
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
cpu_regfile.sv
cpu_decode.sv
cpu_execute.sv
cpu_commit.sv
cpu_top.sv
tb_cpu_top.sv

// File: cpu_decode.sv
`timescale 1ns/100ps
// Decode stage: accepts instruction words, assigns the pc, checks legality and hazards
module cpu_decode #(
  parameter int NUM_REGS = 32
) (
  input  logic                   clk,
  input  logic                   reset,
  input  cpu_isa_pkg::word_t     pc_rtvec,
  input  logic                   inst_valid,
  output logic                   inst_ready,
  input  cpu_isa_pkg::word_t     inst_word,
  output cpu_isa_pkg::reg_idx_t  rs1_idx,
  output cpu_isa_pkg::reg_idx_t  rs2_idx,
  input  cpu_isa_pkg::word_t     rs1_data,
  input  cpu_isa_pkg::word_t     rs2_data,
  input  cpu_isa_pkg::reg_idx_t  exe_busy_rd,
  input  logic                   exe_busy_en,
  input  cpu_isa_pkg::reg_idx_t  cmt_busy_rd,
  input  logic                   cmt_busy_en,
  output logic                   dec_valid,
  input  logic                   dec_ready,
  output cpu_pipe_pkg::dec_rec_t dec_rec
);

  cpu_isa_pkg::opcode_e  opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  cpu_isa_pkg::reg_idx_t rd;
  cpu_isa_pkg::word_t    imm;
  cpu_isa_pkg::alu_op_e  alu_op;
  cpu_isa_pkg::word_t    pc_q;
  logic                  known;
  logic                  uses_rs1;
  logic                  uses_rs2;
  logic                  legal;
  logic                  rd_src1;
  logic                  rd_src2;
  logic                  src1_busy;
  logic                  src2_busy;
  logic                  own_busy;
  logic                  run_q;      // Low until the first cycle out of reset
  logic                  inst_xfer;

  assign opcode  = cpu_isa_pkg::opcode_e'(inst_word[cpu_isa_pkg::OPC_LSB +: 7]);
  assign funct3  = inst_word[cpu_isa_pkg::F3_LSB +: 3];
  assign funct7  = inst_word[cpu_isa_pkg::F7_LSB +: 7];
  assign rd      = inst_word[cpu_isa_pkg::RD_LSB +: cpu_isa_pkg::REG_IDX_W];
  assign rs1_idx = inst_word[cpu_isa_pkg::RS1_LSB +: cpu_isa_pkg::REG_IDX_W];
  assign rs2_idx = inst_word[cpu_isa_pkg::RS2_LSB +: cpu_isa_pkg::REG_IDX_W];

  ////////////////////
  // Opcode and funct to ALU operation
  always_comb begin
    alu_op   = cpu_isa_pkg::ADD;
    imm      = {{20{inst_word[31]}}, inst_word[cpu_isa_pkg::IMM_I_LSB +: 12]};
    known    = 1'b1;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      cpu_isa_pkg::OP: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        if (funct7 == cpu_isa_pkg::F7_ALT && funct3 == cpu_isa_pkg::F3_ADD_SUB) begin
          alu_op = cpu_isa_pkg::SUB;
        end else if (funct7 != cpu_isa_pkg::F7_BASE) begin
          known = 1'b0;
        end else begin
          case (funct3)
            cpu_isa_pkg::F3_ADD_SUB: alu_op = cpu_isa_pkg::ADD;
            cpu_isa_pkg::F3_SLL:     alu_op = cpu_isa_pkg::SLL;
            cpu_isa_pkg::F3_SLT:     alu_op = cpu_isa_pkg::SLT;
            cpu_isa_pkg::F3_XOR:     alu_op = cpu_isa_pkg::XOR;
            cpu_isa_pkg::F3_SRL:     alu_op = cpu_isa_pkg::SRL;
            cpu_isa_pkg::F3_OR:      alu_op = cpu_isa_pkg::OR;
            cpu_isa_pkg::F3_AND:     alu_op = cpu_isa_pkg::AND;
            default:                 known  = 1'b0;  // SLTU
          endcase
        end
      end
      cpu_isa_pkg::OP_IMM: begin
        uses_rs1 = 1'b1;
        case (funct3)
          cpu_isa_pkg::F3_ADD_SUB: alu_op = cpu_isa_pkg::ADD;
          cpu_isa_pkg::F3_XOR:     alu_op = cpu_isa_pkg::XOR;
          cpu_isa_pkg::F3_OR:      alu_op = cpu_isa_pkg::OR;
          cpu_isa_pkg::F3_AND:     alu_op = cpu_isa_pkg::AND;
          default:                 known  = 1'b0;  // Immediate shifts and compares
        endcase
      end
      cpu_isa_pkg::LUI: begin
        alu_op = cpu_isa_pkg::PASS_B;
        imm    = {inst_word[31:cpu_isa_pkg::IMM_U_LSB], 12'b0};
      end
      default: known = 1'b0;
    endcase
  end

  assign legal = known && int'(rd) < NUM_REGS &&
                 (!uses_rs1 || int'(rs1_idx) < NUM_REGS) &&
                 (!uses_rs2 || int'(rs2_idx) < NUM_REGS);

  ////////////////////
  // Hazard interlock, own held record counts as in flight too
  assign rd_src1  = legal && uses_rs1 && rs1_idx != '0;
  assign rd_src2  = legal && uses_rs2 && rs2_idx != '0;
  assign own_busy = dec_valid && dec_rec.wr_en;

  assign src1_busy = rd_src1 &&
                     ((exe_busy_en && exe_busy_rd == rs1_idx) ||
                      (cmt_busy_en && cmt_busy_rd == rs1_idx) ||
                      (own_busy && dec_rec.rd == rs1_idx));
  assign src2_busy = rd_src2 &&
                     ((exe_busy_en && exe_busy_rd == rs2_idx) ||
                      (cmt_busy_en && cmt_busy_rd == rs2_idx) ||
                      (own_busy && dec_rec.rd == rs2_idx));

  assign inst_ready = run_q && !(inst_valid && (src1_busy || src2_busy)) &&
                      (!dec_valid || dec_ready);
  assign inst_xfer  = inst_valid && inst_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      run_q     <= 1'b0;
      pc_q      <= pc_rtvec;  // Reset vector sampled while reset is high
      dec_valid <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (inst_xfer) begin
        dec_valid <= 1'b1;
        pc_q      <= pc_q + cpu_isa_pkg::word_t'(4);
      end else if (dec_ready) begin
        dec_valid <= 1'b0;
      end
    end
  end

  // Record payload
  always_ff @(posedge clk) begin
    if (inst_xfer) begin
      dec_rec.pc        <= pc_q;
      dec_rec.alu_op    <= alu_op;
      dec_rec.operand_a <= rs1_data;
      dec_rec.operand_b <= uses_rs2 ? rs2_data : imm;
      dec_rec.rd        <= rd;
      dec_rec.wr_en     <= legal;
      dec_rec.cause     <= legal ? cpu_pipe_pkg::NONE : cpu_pipe_pkg::ILLEGAL;
    end
  end

  a_dec_hold: assert property (
    @(posedge clk) disable iff (reset)
    dec_valid && !dec_ready |=> dec_valid && $stable(dec_rec)
  );

endmodule

// File: cpu_execute.sv
`timescale 1ns/100ps
// Execute stage: ALU on the decoded operands, registers the commit record
module cpu_execute (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   dec_valid,
  output logic                   dec_ready,
  input  cpu_pipe_pkg::dec_rec_t dec_rec,
  output logic                   exe_valid,
  input  logic                   exe_ready,
  output cpu_pipe_pkg::cmt_rec_t exe_rec,
  output cpu_isa_pkg::reg_idx_t  busy_rd,
  output logic                   busy_en
);

  cpu_isa_pkg::word_t         alu_res;
  logic [cpu_isa_pkg::SHAMT_W-1:0] shamt;
  logic                       legal;
  logic                       dec_xfer;

  assign shamt = dec_rec.operand_b[cpu_isa_pkg::SHAMT_W-1:0];
  assign legal = dec_rec.cause == cpu_pipe_pkg::NONE;

  ////////////////////
  // ALU
  always_comb begin
    alu_res = '0;
    case (dec_rec.alu_op)
      cpu_isa_pkg::ADD:    alu_res = dec_rec.operand_a + dec_rec.operand_b;
      cpu_isa_pkg::SUB:    alu_res = dec_rec.operand_a - dec_rec.operand_b;
      cpu_isa_pkg::AND:    alu_res = dec_rec.operand_a & dec_rec.operand_b;
      cpu_isa_pkg::OR:     alu_res = dec_rec.operand_a | dec_rec.operand_b;
      cpu_isa_pkg::XOR:    alu_res = dec_rec.operand_a ^ dec_rec.operand_b;
      cpu_isa_pkg::SLT: begin
        alu_res[0] = $signed(dec_rec.operand_a) < $signed(dec_rec.operand_b);
      end
      cpu_isa_pkg::SLL:    alu_res = dec_rec.operand_a << shamt;
      cpu_isa_pkg::SRL:    alu_res = dec_rec.operand_a >> shamt;
      cpu_isa_pkg::PASS_B: alu_res = dec_rec.operand_b;
      default:             alu_res = '0;
    endcase
  end

  // Ready when empty or draining this cycle
  assign dec_ready = !exe_valid || exe_ready;
  assign dec_xfer  = dec_valid && dec_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      exe_valid <= 1'b0;
    end else if (dec_xfer) begin
      exe_valid <= 1'b1;
    end else if (exe_ready) begin
      exe_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_xfer) begin
      exe_rec.pc     <= dec_rec.pc;
      exe_rec.rd     <= dec_rec.rd;
      exe_rec.wr_en  <= dec_rec.wr_en && legal;
      exe_rec.result <= legal ? alu_res : '0;  // Illegal commits zero
      exe_rec.cause  <= dec_rec.cause;
    end
  end

  assign busy_rd = exe_rec.rd;
  assign busy_en = exe_valid && exe_rec.wr_en;

endmodule

// File: cpu_isa_pkg.sv
// ISA package for the integer core slice: widths, opcodes, ALU operations and field positions
package cpu_isa_pkg;

  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int SHAMT_W   = 5;

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  ////////////////////
  // Major opcodes, subset of RV32I
  typedef enum logic [6:0] {
    OP     = 7'b0110011,  // Register-register ALU
    OP_IMM = 7'b0010011,  // Register-immediate ALU
    LUI    = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,     // Signed compare
    SLL,
    SRL,
    PASS_B   // LUI result is the immediate
  } alu_op_e;

  ////////////////////
  // Instruction word field positions
  localparam int OPC_LSB   = 0;
  localparam int RD_LSB    = 7;
  localparam int F3_LSB    = 12;
  localparam int RS1_LSB   = 15;
  localparam int RS2_LSB   = 20;
  localparam int F7_LSB    = 25;
  localparam int IMM_I_LSB = 20;
  localparam int IMM_U_LSB = 12;

  // funct3 and funct7 encodings
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_ALT     = 7'b0100000;  // SUB

endpackage

// File: cpu_pipe_pkg.sv
// Pipeline package for the integer core slice: stage records and commit cause
package cpu_pipe_pkg;

  // Commit cause, kept narrow like the debug cause field
  typedef enum logic [1:0] {
    NONE    = 2'd0,
    ILLEGAL = 2'd1
  } cause_e;

  ////////////////////
  // Decode to execute, 108 bits
  typedef struct packed {
    cpu_isa_pkg::word_t    pc;
    cpu_isa_pkg::alu_op_e  alu_op;
    cpu_isa_pkg::word_t    operand_a;
    cpu_isa_pkg::word_t    operand_b;   // rs2 or immediate
    cpu_isa_pkg::reg_idx_t rd;
    logic                  wr_en;
    cause_e                cause;
  } dec_rec_t;

  ////////////////////
  // Execute to commit, also the commit output, 72 bits
  typedef struct packed {
    cpu_isa_pkg::word_t    pc;
    cpu_isa_pkg::reg_idx_t rd;
    logic                  wr_en;       // Low for illegal records
    cpu_isa_pkg::word_t    result;
    cause_e                cause;
  } cmt_rec_t;

endpackage

// File: cpu_regfile.sv
`timescale 1ns/100ps
// Integer register file with two combinational read ports, one write port and x0 tied to zero
module cpu_regfile #(
  parameter int NUM_REGS = 32
) (
  input  logic                  clk,
  input  logic                  reset,
  input  cpu_isa_pkg::reg_idx_t rs1_idx,
  input  cpu_isa_pkg::reg_idx_t rs2_idx,
  output cpu_isa_pkg::word_t    rs1_data,
  output cpu_isa_pkg::word_t    rs2_data,
  input  logic                  wb_en,
  input  cpu_isa_pkg::reg_idx_t wb_idx,
  input  cpu_isa_pkg::word_t    wb_data
);

  localparam int IDX_W = $clog2(NUM_REGS);

  cpu_isa_pkg::word_t regs [NUM_REGS];

  // Out of range indices read zero, decode flags them illegal anyway
  assign rs1_data = (rs1_idx != '0 && int'(rs1_idx) < NUM_REGS) ?
                    regs[rs1_idx[IDX_W-1:0]] : '0;
  assign rs2_data = (rs2_idx != '0 && int'(rs2_idx) < NUM_REGS) ?
                    regs[rs2_idx[IDX_W-1:0]] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_idx != '0) begin  // x0 writes dropped
      regs[wb_idx[IDX_W-1:0]] <= wb_data;
    end
  end

  // Commit only writes registers that decode found in range
  a_wb_idx_range: assert property (
    @(posedge clk) disable iff (reset)
    wb_en |-> int'(wb_idx) < NUM_REGS
  );

endmodule

// File: cpu_top.sv
`timescale 1ns/100ps
// Core slice top: decode, execute and commit stages around the register file
module cpu_top #(
  parameter int NUM_REGS = 32
) (
  input  logic                   clk,
  input  logic                   reset,
  input  cpu_isa_pkg::word_t     pc_rtvec,
  input  logic                   inst_valid,
  output logic                   inst_ready,
  input  cpu_isa_pkg::word_t     inst_word,
  output logic                   cmt_valid,
  input  logic                   cmt_ready,
  output cpu_pipe_pkg::cmt_rec_t cmt_rec
);

  cpu_isa_pkg::reg_idx_t  rs1_idx;
  cpu_isa_pkg::reg_idx_t  rs2_idx;
  cpu_isa_pkg::word_t     rs1_data;
  cpu_isa_pkg::word_t     rs2_data;
  logic                   dec_valid;
  logic                   dec_ready;
  cpu_pipe_pkg::dec_rec_t dec_rec;
  logic                   exe_valid;
  logic                   exe_ready;
  cpu_pipe_pkg::cmt_rec_t exe_rec;
  cpu_isa_pkg::reg_idx_t  exe_busy_rd;
  logic                   exe_busy_en;
  cpu_isa_pkg::reg_idx_t  cmt_busy_rd;
  logic                   cmt_busy_en;
  logic                   wb_en;
  cpu_isa_pkg::reg_idx_t  wb_idx;
  cpu_isa_pkg::word_t     wb_data;

  cpu_regfile #(.NUM_REGS(NUM_REGS)) u_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_en    (wb_en),
    .wb_idx   (wb_idx),
    .wb_data  (wb_data)
  );

  ////////////////////
  // Pipeline stages
  cpu_decode #(.NUM_REGS(NUM_REGS)) u_decode (
    .clk         (clk),
    .reset       (reset),
    .pc_rtvec    (pc_rtvec),
    .inst_valid  (inst_valid),
    .inst_ready  (inst_ready),
    .inst_word   (inst_word),
    .rs1_idx     (rs1_idx),
    .rs2_idx     (rs2_idx),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .exe_busy_rd (exe_busy_rd),
    .exe_busy_en (exe_busy_en),
    .cmt_busy_rd (cmt_busy_rd),
    .cmt_busy_en (cmt_busy_en),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec_rec     (dec_rec)
  );

  cpu_execute u_execute (
    .clk       (clk),
    .reset     (reset),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec_rec   (dec_rec),
    .exe_valid (exe_valid),
    .exe_ready (exe_ready),
    .exe_rec   (exe_rec),
    .busy_rd   (exe_busy_rd),
    .busy_en   (exe_busy_en)
  );

  cpu_commit u_commit (
    .clk       (clk),
    .reset     (reset),
    .exe_valid (exe_valid),
    .exe_ready (exe_ready),
    .exe_rec   (exe_rec),
    .cmt_valid (cmt_valid),
    .cmt_ready (cmt_ready),
    .cmt_rec   (cmt_rec),
    .wb_en     (wb_en),
    .wb_idx    (wb_idx),
    .wb_data   (wb_data),
    .busy_rd   (cmt_busy_rd),  // Cleared at the commit edge
    .busy_en   (cmt_busy_en)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the core slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f cpu_core.f --top-module tb_cpu_top \
  -Mdir "$OBJ" -o tb_cpu_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/tb_cpu_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tb_cpu_top.sv
`timescale 1ns/100ps
// Testbench for the core slice: instruction table from a reference model, random commit back-pressure
module tb_cpu_top;

  localparam int NUM_REGS     = 32;
  localparam int NUM_TESTS    = 24;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_CYCLES   = NUM_TESTS * 20 + 100;
  localparam logic [31:0] SEED = 32'h3434;
  localparam cpu_isa_pkg::word_t PC_RTVEC = 32'h0000_2000;

  typedef struct packed {
    cpu_isa_pkg::word_t    word;
    cpu_pipe_pkg::cause_e  cause;
    cpu_isa_pkg::reg_idx_t rd;
    cpu_isa_pkg::word_t    result;
  } test_t;

  logic                   clk;
  logic                   reset;
  cpu_isa_pkg::word_t     pc_rtvec;
  logic                   inst_valid;
  logic                   inst_ready;
  cpu_isa_pkg::word_t     inst_word;
  logic                   cmt_valid;
  logic                   cmt_ready;
  cpu_pipe_pkg::cmt_rec_t cmt_rec;

  test_t              tbl [NUM_TESTS];
  cpu_isa_pkg::word_t model_regs [32];  // Reference register state
  int                 n_tbl;
  int                 cmt_idx;
  int                 cycle_count;
  int                 pass_count;
  int                 fail_count;
  int                 error_count;
  logic               test_ok;

  cpu_top #(.NUM_REGS(NUM_REGS)) cpu_top_inst (
    .clk        (clk),
    .reset      (reset),
    .pc_rtvec   (pc_rtvec),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .inst_word  (inst_word),
    .cmt_valid  (cmt_valid),
    .cmt_ready  (cmt_ready),
    .cmt_rec    (cmt_rec)
  );

  always #10 clk = ~clk;

  ////////////////////
  // Reference model
  task automatic add_entry(input cpu_isa_pkg::word_t word, input cpu_pipe_pkg::cause_e cause,
                           input int rd, input cpu_isa_pkg::word_t result);
    tbl[n_tbl].word   = word;
    tbl[n_tbl].cause  = cause;
    tbl[n_tbl].rd     = cpu_isa_pkg::reg_idx_t'(rd);
    tbl[n_tbl].result = result;
    n_tbl++;
    if (cause == cpu_pipe_pkg::NONE && rd != 0) begin
      model_regs[rd] = result;  // x0 stays zero
    end
  endtask

  task automatic push_rr(input string mn, input int rd, input int rs1, input int rs2);
    cpu_isa_pkg::word_t a;
    cpu_isa_pkg::word_t b;
    cpu_isa_pkg::word_t res;
    logic [2:0]         f3;
    logic [6:0]         f7;
    a  = model_regs[rs1];
    b  = model_regs[rs2];
    f7 = (mn == "sub") ? 7'b0100000 : 7'b0000000;
    case (mn)
      "sll":   f3 = 3'b001;
      "slt":   f3 = 3'b010;
      "xor":   f3 = 3'b100;
      "srl":   f3 = 3'b101;
      "or":    f3 = 3'b110;
      "and":   f3 = 3'b111;
      default: f3 = 3'b000;  // add and sub
    endcase
    case (mn)
      "sub":   res = a - b;
      "sll":   res = a << b[4:0];
      "slt":   res = {31'b0, $signed(a) < $signed(b)};
      "xor":   res = a ^ b;
      "srl":   res = a >> b[4:0];
      "or":    res = a | b;
      "and":   res = a & b;
      default: res = a + b;
    endcase
    add_entry({f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011}, cpu_pipe_pkg::NONE, rd, res);
  endtask

  task automatic push_ri(input string mn, input int rd, input int rs1, input int imm);
    cpu_isa_pkg::word_t a;
    cpu_isa_pkg::word_t b;
    cpu_isa_pkg::word_t res;
    logic [2:0]         f3;
    a = model_regs[rs1];
    b = cpu_isa_pkg::word_t'(imm);  // Sign extended 12 bit immediate
    case (mn)
      "xori":  f3 = 3'b100;
      "ori":   f3 = 3'b110;
      "andi":  f3 = 3'b111;
      default: f3 = 3'b000;
    endcase
    case (mn)
      "xori":  res = a ^ b;
      "ori":   res = a | b;
      "andi":  res = a & b;
      default: res = a + b;
    endcase
    add_entry({imm[11:0], 5'(rs1), f3, 5'(rd), 7'b0010011}, cpu_pipe_pkg::NONE, rd, res);
  endtask

  task automatic push_lui(input int rd, input int imm20);
    add_entry({imm20[19:0], 5'(rd), 7'b0110111}, cpu_pipe_pkg::NONE, rd,
              {imm20[19:0], 12'h000});
  endtask

  // Illegal words commit zero and leave rd alone
  task automatic push_illegal(input cpu_isa_pkg::word_t word);
    add_entry(word, cpu_pipe_pkg::ILLEGAL, int'(word[11:7]), '0);
  endtask

  task automatic build_table();
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    n_tbl = 0;
    push_ri("addi", 1, 0, 5);
    push_ri("addi", 2, 0, -3);
    push_rr("add", 3, 1, 2);      // Back to back on x1 and x2
    push_rr("sub", 4, 1, 2);
    push_rr("slt", 5, 2, 1);      // Negative operand
    push_rr("slt", 6, 1, 2);
    push_lui(7, 'h12345);
    push_ri("ori", 8, 7, 'h678);
    push_ri("xori", 9, 8, -1);
    push_ri("andi", 10, 9, 'h0f0);
    push_rr("sll", 11, 8, 1);
    push_rr("srl", 12, 9, 4);
    push_rr("and", 13, 8, 9);
    push_rr("or", 14, 8, 9);
    push_rr("xor", 15, 14, 8);
    push_ri("addi", 0, 1, 7);     // Write to x0
    push_rr("add", 16, 0, 1);
    push_illegal({20'h00123, 5'd16, 7'b1111111});
    push_ri("addi", 17, 16, 0);   // Old x16
    push_illegal({7'b0000000, 5'd2, 5'd1, 3'b011, 5'd1, 7'b0110011});  // SLTU
    push_rr("add", 18, 1, 1);
    push_rr("sub", 19, 0, 18);
    push_rr("srl", 20, 19, 1);
    push_rr("sll", 21, 19, 19);   // Shift amount from low 5 bits only
  endtask

  ////////////////////
  // Compare tasks
  task automatic check_word(input string name, input cpu_isa_pkg::word_t exp_val,
                            input cpu_isa_pkg::word_t act_val);
    if (act_val !== exp_val) begin
      $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp_val, act_val);
      error_count++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_reg(input string name, input cpu_isa_pkg::reg_idx_t exp_val,
                           input cpu_isa_pkg::reg_idx_t act_val);
    if (act_val !== exp_val) begin
      $display("mismatch at %0t ns: %s expected x%0d got x%0d", $time, name, exp_val, act_val);
      error_count++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_cause(input string name, input cpu_pipe_pkg::cause_e exp_val,
                             input cpu_pipe_pkg::cause_e act_val);
    if (act_val !== exp_val) begin
      $display("mismatch at %0t ns: %s expected %s(%0d) got %s(%0d)", $time, name,
               exp_val.name(), exp_val, act_val.name(), act_val);
      error_count++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_flag(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("mismatch at %0t ns: %s expected %b got %b", $time, name, exp_val, act_val);
      error_count++;
      test_ok = 1'b0;
    end
  endtask

  ////////////////////
  // Commit monitor, one line per record
  always @(posedge clk) begin
    if (!reset && cmt_valid && cmt_ready) begin
      if (cmt_idx >= NUM_TESTS) begin
        $display("extra commit record at %0t ns after all %0d table entries", $time, NUM_TESTS);
        error_count++;
      end else begin
        test_ok = 1'b1;
        check_word("cmt_rec.pc", PC_RTVEC + cpu_isa_pkg::word_t'(4 * cmt_idx), cmt_rec.pc);
        check_cause("cmt_rec.cause", tbl[cmt_idx].cause, cmt_rec.cause);
        check_reg("cmt_rec.rd", tbl[cmt_idx].rd, cmt_rec.rd);
        check_word("cmt_rec.result", tbl[cmt_idx].result, cmt_rec.result);
        check_flag("cmt_rec.wr_en", tbl[cmt_idx].cause == cpu_pipe_pkg::NONE, cmt_rec.wr_en);
        if (test_ok) begin
          pass_count++;
        end else begin
          fail_count++;
        end
        $display("test %0d word %h pc %h result %h: %s", cmt_idx, tbl[cmt_idx].word,
                 cmt_rec.pc, cmt_rec.result, test_ok ? "ok" : "failed");
      end
      cmt_idx++;
    end
  end

  // Back-pressure on the commit channel, about one cycle in four
  initial begin
    void'($urandom(SEED));
    cmt_ready <= 1'b0;
    forever begin
      @(posedge clk);
      cmt_ready <= ($urandom() % 4) != 0;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d of %0d records committed",
               cycle_count, cmt_idx, NUM_TESTS);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    pc_rtvec    = PC_RTVEC;
    inst_valid  = 1'b0;
    inst_word   = '0;
    cmt_idx     = 0;
    cycle_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    error_count = 0;
    test_ok     = 1'b1;
    build_table();

    // Nothing leaves the core during reset
    repeat (RESET_CYCLES - 1) begin
      @(negedge clk);
      check_flag("cmt_valid", 1'b0, cmt_valid);
      check_flag("inst_ready", 1'b0, inst_ready);
    end
    @(posedge clk);
    reset <= 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_flag("cmt_valid", 1'b0, cmt_valid);
    end

    @(posedge clk);
    for (int i = 0; i < NUM_TESTS; i++) begin
      inst_valid <= 1'b1;
      inst_word  <= tbl[i].word;
      do begin
        @(posedge clk);
      end while (!inst_ready);
    end
    inst_valid <= 1'b0;

    wait (cmt_idx >= NUM_TESTS);
    repeat (8) @(posedge clk);  // Room for a stray extra record
    $display("%0d tests: %0d passed, %0d failed, %0d check errors",
             NUM_TESTS, pass_count, fail_count, error_count);
    if (error_count == 0 && pass_count == NUM_TESTS) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
